//--- include/spi_ctrl_defines.svh
/*
  board control block constants
  frame length, register map addresses and reset values
*/
`ifndef SPI_CTRL_DEFINES_SVH
`define SPI_CTRL_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// spi framing

`define SPI_FRAME_BITS 16      // address byte then clr and set nibbles
`define SYNC_STAGES 2          // flops per spi input

////////////////////////////////////////////////////////////////////////////
// register map

`define REG_ADDR_LED      8'd7
`define REG_ADDR_MUX      8'd8   // peripheral routing
`define REG_ADDR_DAC      8'd9
`define REG_ADDR_RAILS    8'd10
`define REG_ADDR_SOFT_RST 8'd11  // no storage behind this one
`define REG_ADDR_DAC_REF  8'd12
`define REG_ADDR_ADC      8'd13
`define REG_ADDR_RELAY    8'd14

// relays come up with every bit set
// all other fields reset to zero
`define REG_RESET_RELAY 4'b1111

`endif

//--- source/spi_ctrl_pkg.sv
/*
  board control types
  spi command word, its two readings, the register bank and routing vectors
*/
package spi_ctrl_pkg;

  // one bit per downstream peripheral
  // bit 0 adc03, bit 1 dac, bit 2 flash, bit 3 adc02
  typedef logic [3:0] periph_vec_t;

  // decoded view of a received frame, msb first on the wire
  typedef struct packed {
    logic [7:0] addr;  // first byte in
    logic [3:0] clr;   // frame bits 7..4
    logic [3:0] set;   // frame bits 3..0
  } spi_cmd_t;

  // same 16 bits seen as shift register or as command
  typedef union packed {
    logic [15:0] raw;
    spi_cmd_t    cmd;
  } spi_frame_u;

  // control bank as driven onto the board pins
  typedef struct packed {
    logic [3:0]  led;
    periph_vec_t mux;      // which peripheral gets cs
    logic [3:0]  dac;      // ldac, uni/bip a and b, rst
    logic [3:0]  rails;
    logic [3:0]  dac_ref;  // ref mux a/b
    logic [3:0]  adc;      // adc02 mode pins and rst
    logic [3:0]  relay;
    logic [3:0]  spare;    // pads to 32 bits, always zero
  } ctrl_regs_t;

endpackage

//--- source/spi_frame_rx.sv
/*
  spi frame receiver for the register bank
  syncs the pins into clk, shifts in 16 bit frames and shifts out readback
*/
`include "spi_ctrl_defines.svh"

module spi_frame_rx (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     sclk,
  input  logic                     cs_n,
  input  logic                     special_n,
  input  logic                     mosi,
  input  logic [3:0]               rd_data,      // from reg file, same cycle
  output logic                     addr_valid,
  output logic [7:0]               rd_addr,
  output logic                     frame_valid,
  output spi_ctrl_pkg::spi_frame_u frame,
  output logic                     bank_miso
);

  localparam int CNT_W = $clog2(`SPI_FRAME_BITS + 2);
  localparam logic [CNT_W-1:0] CNT_ADDR = CNT_W'(`SPI_FRAME_BITS / 2 - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`SPI_FRAME_BITS);
  localparam logic [CNT_W-1:0] CNT_SAT  = CNT_W'(`SPI_FRAME_BITS + 1);  // too long
  localparam logic [3:0] PIN_IDLE = 4'b0110;  // sclk low, selects high

  logic [`SYNC_STAGES-1:0][3:0] sync_q;
  logic                         sclk_s, cs_s, special_s, mosi_s;
  logic                         sclk_q, cs_q;  // previous synced values
  logic                         sclk_rise, sclk_fall, cs_rise;
  logic                         bank_sel;
  logic [CNT_W-1:0]             bit_cnt;
  spi_ctrl_pkg::spi_frame_u     frame_q;
  logic [7:0]                   out_q;         // readback shifter
  logic                         addr_valid_q, frame_valid_q, miso_q;

  ////////////////////////////////////////////////////////////////////////////
  // pin sync and edge detect

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync_q <= {`SYNC_STAGES{PIN_IDLE}};
      sclk_q <= 1'b0;
      cs_q   <= 1'b1;
    end
    else
    begin
      sync_q <= {sync_q[`SYNC_STAGES-2:0], {sclk, cs_n, special_n, mosi}};
      sclk_q <= sclk_s;
      cs_q   <= cs_s;
    end
  end

  assign {sclk_s, cs_s, special_s, mosi_s} = sync_q[`SYNC_STAGES-1];
  assign sclk_rise = sclk_s & ~sclk_q;   // mode 0 sample edge
  assign sclk_fall = ~sclk_s & sclk_q;
  assign cs_rise   = cs_s & ~cs_q;       // end of any frame
  assign bank_sel  = ~cs_s & ~special_s;

  ////////////////////////////////////////////////////////////////////////////
  // bit count and strobes

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt       <= '0;
      addr_valid_q  <= 1'b0;
      frame_valid_q <= 1'b0;
    end
    else
    begin
      addr_valid_q  <= 1'b0;
      frame_valid_q <= 1'b0;
      if (cs_rise)
      begin
        frame_valid_q <= (bit_cnt == CNT_FULL);  // short or long frames dropped
        bit_cnt       <= '0;
      end
      else if (bank_sel && sclk_rise)
      begin
        addr_valid_q <= (bit_cnt == CNT_ADDR);   // 8th bit arriving now
        if (bit_cnt != CNT_SAT)
          bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // msb first, lsb end takes mosi
  always_ff @(posedge clk)
  begin
    if (bank_sel && sclk_rise)
      frame_q.raw <= {frame_q.raw[`SPI_FRAME_BITS-2:0], mosi_s};
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback shifter, changes on falling sclk

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_q  <= '0;
      miso_q <= 1'b0;
    end
    else if (cs_rise)
    begin
      out_q  <= '0;
      miso_q <= 1'b0;
    end
    else if (addr_valid_q)
      out_q <= {4'b0000, rd_data};  // zero extend to a byte
    else if (bank_sel && sclk_fall)
    begin
      miso_q <= out_q[7];
      out_q  <= {out_q[6:0], 1'b0};
    end
  end

  assign addr_valid  = addr_valid_q;
  assign rd_addr     = frame_q.raw[7:0];  // only first byte is in at addr_valid
  assign frame_valid = frame_valid_q;
  assign frame       = frame_q;
  assign bank_miso   = miso_q;

endmodule

//--- source/ctrl_reg_file.sv
/*
  control register bank
  set/clear/toggle update per frame, soft reset, and readback by address
*/
`include "spi_ctrl_defines.svh"

module ctrl_reg_file (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     frame_valid,
  input  spi_ctrl_pkg::spi_frame_u frame,
  input  logic [7:0]               rd_addr,
  output logic [3:0]               rd_data,
  output spi_ctrl_pkg::ctrl_regs_t regs
);

  localparam spi_ctrl_pkg::ctrl_regs_t REGS_RESET = '{
    led:     4'h0,
    mux:     4'h0,
    dac:     4'h0,
    rails:   4'h0,
    dac_ref: 4'h0,
    adc:     4'h0,
    relay:   `REG_RESET_RELAY,
    spare:   4'h0
  };

  spi_ctrl_pkg::ctrl_regs_t regs_q;
  spi_ctrl_pkg::spi_cmd_t   cmd;

  assign cmd = frame.cmd;

  // bits in both set and clr toggle
  // otherwise set first, then clear
  function automatic logic [3:0] apply_cmd(input logic [3:0] cur,
                                           input spi_ctrl_pkg::spi_cmd_t c);
    logic [3:0] both;
    both = c.set & c.clr;
    if (|both)
      return cur ^ both;
    return (cur | c.set) & ~c.clr;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // write side

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      regs_q <= REGS_RESET;
    else if (frame_valid)
    begin
      case (cmd.addr)
        `REG_ADDR_LED:      regs_q.led     <= apply_cmd(regs_q.led, cmd);
        `REG_ADDR_MUX:      regs_q.mux     <= apply_cmd(regs_q.mux, cmd);
        `REG_ADDR_DAC:      regs_q.dac     <= apply_cmd(regs_q.dac, cmd);
        `REG_ADDR_RAILS:    regs_q.rails   <= apply_cmd(regs_q.rails, cmd);
        `REG_ADDR_SOFT_RST: regs_q         <= REGS_RESET;  // whole bank
        `REG_ADDR_DAC_REF:  regs_q.dac_ref <= apply_cmd(regs_q.dac_ref, cmd);
        `REG_ADDR_ADC:      regs_q.adc     <= apply_cmd(regs_q.adc, cmd);
        `REG_ADDR_RELAY:    regs_q.relay   <= apply_cmd(regs_q.relay, cmd);
        default:            ;  // unknown address, frame ignored
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback, combinational for the receiver

  always_comb
  begin
    case (rd_addr)
      `REG_ADDR_LED:     rd_data = regs_q.led;
      `REG_ADDR_MUX:     rd_data = regs_q.mux;
      `REG_ADDR_DAC:     rd_data = regs_q.dac;
      `REG_ADDR_RAILS:   rd_data = regs_q.rails;
      `REG_ADDR_DAC_REF: rd_data = regs_q.dac_ref;
      `REG_ADDR_ADC:     rd_data = regs_q.adc;
      `REG_ADDR_RELAY:   rd_data = regs_q.relay;
      default:           rd_data = 4'h0;  // includes soft reset
    endcase
  end

  assign regs = regs_q;

endmodule

//--- source/spi_route.sv
/*
  spi routing to the downstream peripherals
  steers chip select by the mux register and picks the miso source
*/
module spi_route (
  input  logic                      cs_n,
  input  logic                      special_n,
  input  spi_ctrl_pkg::periph_vec_t mux,
  input  spi_ctrl_pkg::periph_vec_t miso_vec,
  input  logic                      bank_miso,
  output spi_ctrl_pkg::periph_vec_t cs_vec,
  output logic                      miso
);

  spi_ctrl_pkg::periph_vec_t sel;      // peripherals with cs asserted
  spi_ctrl_pkg::periph_vec_t miso_on;  // selected miso lines

  ////////////////////////////////////////////////////////////////////////////
  // chip select

  // straight from the pins so pass-through keeps spi timing
  assign sel = mux & {4{~cs_n}};

  // bank frame keeps every peripheral deselected
  // no spurious writes while the fpga is addressed
  assign cs_vec = special_n ? ~sel : '1;

  ////////////////////////////////////////////////////////////////////////////
  // miso

  assign miso_on = mux & miso_vec;

  always_comb
  begin
    if (!special_n)
      miso = bank_miso;   // register bank readback
    else
      miso = |miso_on;    // any selected peripheral driving high
  end

endmodule

//--- source/spi_ctrl_top.sv
/*
  board control top
  spi receiver, control register bank and peripheral routing
*/
module spi_ctrl_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      sclk,
  input  logic                      cs_n,
  input  logic                      special_n,
  input  logic                      mosi,
  input  spi_ctrl_pkg::periph_vec_t miso_vec,
  output logic                      miso,
  output spi_ctrl_pkg::periph_vec_t cs_vec,
  output spi_ctrl_pkg::ctrl_regs_t  regs
);

  logic [7:0]               rd_addr;
  logic [3:0]               rd_data;
  logic                     frame_valid;
  spi_ctrl_pkg::spi_frame_u frame;
  logic                     bank_miso;

  spi_frame_rx u_frame_rx (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mosi        (mosi),
    .rd_data     (rd_data),
    .addr_valid  (),
    .rd_addr     (rd_addr),
    .frame_valid (frame_valid),
    .frame       (frame),
    .bank_miso   (bank_miso)
  );

  ctrl_reg_file u_reg_file (
    .clk         (clk),
    .arst_n      (arst_n),
    .frame_valid (frame_valid),
    .frame       (frame),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .regs        (regs)
  );

  // combinational, pins straight through
  spi_route u_route (
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mux         (regs.mux),
    .miso_vec    (miso_vec),
    .bank_miso   (bank_miso),
    .cs_vec      (cs_vec),
    .miso        (miso)
  );

endmodule

//--- dv/spi_ctrl_checker.sv
/*
  spi control block checker
  chip select, frame strobe and reset properties, bound into the top level
*/
`include "spi_ctrl_defines.svh"

module spi_ctrl_checker (
  input logic                      clk,
  input logic                      arst_n,
  input logic                      cs_n,
  input logic                      special_n,
  input spi_ctrl_pkg::periph_vec_t cs_vec,
  input logic                      frame_valid,
  input spi_ctrl_pkg::ctrl_regs_t  regs
);

  // relay field sits at bits 7..4, the rest is zero
  localparam logic [31:0] REGS_RESET = {24'h0, `REG_RESET_RELAY, 4'h0};

  // no peripheral selected during bank frames or when idle
  cs_idle_high: assert property (@(posedge clk) (!special_n || cs_n) |-> (cs_vec == 4'hf))
    else $error("cs_vec not all high while special_n low or cs_n high");

  // one clk pulse per frame
  frame_pulse: assert property (@(posedge clk) disable iff (!arst_n)
                                frame_valid |=> !frame_valid)
    else $error("frame_valid high in two consecutive cycles");

  reset_values: assert property (@(posedge clk) $rose(arst_n) |-> (regs == REGS_RESET))
    else $error("regs differ from reset values after reset release");

endmodule

bind spi_ctrl_top spi_ctrl_checker u_checker (
  .clk         (clk),
  .arst_n      (arst_n),
  .cs_n        (cs_n),
  .special_n   (special_n),
  .cs_vec      (cs_vec),
  .frame_valid (frame_valid),
  .regs        (regs)
);

//--- dv/spi_ctrl_tb.sv
/*
  testbench for the spi board control block
  random set/clear/toggle frames, readback, soft reset, bad frames, routing
*/
`include "spi_ctrl_defines.svh"

module spi_ctrl_tb;

  localparam int HALF_CLKS  = 8;                                       // clk per sclk half
  localparam int FRAME_CLKS = (`SPI_FRAME_BITS + 4) * 2 * HALF_CLKS;   // bits plus gaps

  logic                      clk, arst_n, sclk, cs_n, special_n, mosi;
  spi_ctrl_pkg::periph_vec_t miso_vec, cs_vec, exp_cs;
  logic                      miso, exp_miso;
  spi_ctrl_pkg::ctrl_regs_t  regs, model, exp_regs;
  logic [7:0]                rb_exp, rb_got;   // readback byte
  logic                      rb_check, route_check;
  string                     test_name;
  int                        checks_req, checks_done;
  event                      check_ev;

  spi_ctrl_top uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .special_n (special_n),
    .mosi      (mosi),
    .miso_vec  (miso_vec),
    .miso      (miso),
    .cs_vec    (cs_vec),
    .regs      (regs)
  );

  always #2 clk = ~clk;  // period 4

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  function automatic spi_ctrl_pkg::ctrl_regs_t reset_regs();
    spi_ctrl_pkg::ctrl_regs_t r;
    r       = '0;
    r.relay = `REG_RESET_RELAY;  // relays start closed
    return r;
  endfunction

  // shared bits toggle, otherwise clr wins over set
  function automatic logic [3:0] update_nibble(input logic [3:0] cur, input logic [3:0] clr,
                                               input logic [3:0] set);
    logic [3:0] shared;
    logic [3:0] nxt;
    shared = set & clr;
    nxt    = cur;
    for (int b = 0; b < 4; b++)
    begin
      if (shared != 4'h0)
        nxt[b] = shared[b] ? ~cur[b] : cur[b];
      else if (clr[b])
        nxt[b] = 1'b0;
      else if (set[b])
        nxt[b] = 1'b1;
    end
    return nxt;
  endfunction

  function automatic spi_ctrl_pkg::ctrl_regs_t ref_update(input spi_ctrl_pkg::ctrl_regs_t r,
                                                          input logic [7:0] addr,
                                                          input logic [3:0] clr,
                                                          input logic [3:0] set);
    spi_ctrl_pkg::ctrl_regs_t n;
    n = r;
    case (addr)
      `REG_ADDR_LED:      n.led     = update_nibble(r.led, clr, set);
      `REG_ADDR_MUX:      n.mux     = update_nibble(r.mux, clr, set);
      `REG_ADDR_DAC:      n.dac     = update_nibble(r.dac, clr, set);
      `REG_ADDR_RAILS:    n.rails   = update_nibble(r.rails, clr, set);
      `REG_ADDR_SOFT_RST: n         = reset_regs();
      `REG_ADDR_DAC_REF:  n.dac_ref = update_nibble(r.dac_ref, clr, set);
      `REG_ADDR_ADC:      n.adc     = update_nibble(r.adc, clr, set);
      `REG_ADDR_RELAY:    n.relay   = update_nibble(r.relay, clr, set);
      default:            n         = r;  // unknown, dropped
    endcase
    return n;
  endfunction

  function automatic logic [3:0] field_of(input spi_ctrl_pkg::ctrl_regs_t r,
                                          input logic [7:0] addr);
    case (addr)
      `REG_ADDR_LED:     return r.led;
      `REG_ADDR_MUX:     return r.mux;
      `REG_ADDR_DAC:     return r.dac;
      `REG_ADDR_RAILS:   return r.rails;
      `REG_ADDR_DAC_REF: return r.dac_ref;
      `REG_ADDR_ADC:     return r.adc;
      `REG_ADDR_RELAY:   return r.relay;
      default:           return 4'h0;  // soft reset reads zero too
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare side

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL %s expected %h actual %h", name, exp, act);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at first mismatch");
  endtask

  always @(check_ev)
  begin
    assert (regs === exp_regs)
      else value_error({test_name, " regs"}, exp_regs, regs);
    if (rb_check)
      assert (rb_got === rb_exp)
        else value_error({test_name, " readback"}, rb_exp, rb_got);
    if (route_check)
    begin
      assert (cs_vec === exp_cs)
        else value_error({test_name, " cs_vec"}, exp_cs, cs_vec);
      assert (miso === exp_miso)
        else value_error({test_name, " miso"}, exp_miso, miso);
    end
    checks_done++;
  end

  // hand expectations over and wait for the compare to finish
  task automatic run_check(input string name);
    test_name = name;
    exp_regs  = model;
    checks_req++;
    -> check_ev;
    wait (checks_done == checks_req);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // spi master, mode 0, msb first

  task automatic spi_xfer(input logic [31:0] word, input int nbits, output logic [7:0] rb);
    rb        = 8'h00;
    special_n = 1'b0;  // bank frame
    cs_n      = 1'b0;
    repeat (HALF_CLKS) @(negedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      mosi = word[nbits-1-i];
      repeat (HALF_CLKS) @(negedge clk);
      if (i >= 8 && i < 16)
        rb = {rb[6:0], miso};  // sampled just before the rising edge
      sclk = 1'b1;
      repeat (HALF_CLKS) @(negedge clk);
      sclk = 1'b0;
    end
    repeat (HALF_CLKS) @(negedge clk);
    cs_n      = 1'b1;
    special_n = 1'b1;
    mosi      = 1'b0;
  endtask

  task automatic write_frame(input logic [7:0] addr, input logic [3:0] clr,
                             input logic [3:0] set, input string name);
    logic [7:0] rb;
    spi_xfer({16'h0, addr, clr, set}, `SPI_FRAME_BITS, rb);
    rb_exp = {4'h0, field_of(model, addr)};  // value before the update
    model  = ref_update(model, addr, clr, set);
    repeat (HALF_CLKS) @(negedge clk);        // write lands within 4 clk
    rb_got   = rb;
    rb_check = 1'b1;
    run_check(name);
    rb_check = 1'b0;
  endtask

  // wrong bit count, must leave the bank alone
  // the last bits shifted in still decode as a led command
  task automatic bad_frame(input logic [31:0] word, input int nbits, input string name);
    logic [7:0] rb;
    spi_xfer(word, nbits, rb);
    repeat (HALF_CLKS) @(negedge clk);
    run_check(name);
  endtask

  // peripheral transfer with special_n high
  task automatic route_pass(input int nsamples);
    spi_ctrl_pkg::periph_vec_t drv;
    special_n   = 1'b1;
    cs_n        = 1'b0;
    route_check = 1'b1;
    for (int j = 0; j < nsamples; j++)
    begin
      drv      = 4'($urandom);
      miso_vec = drv;
      @(negedge clk);  // settle a full cycle
      exp_cs   = ~model.mux;
      exp_miso = |(model.mux & drv);
      run_check("route");
    end
    cs_n        = 1'b1;
    route_check = 1'b0;
    miso_vec    = '0;
    repeat (HALF_CLKS) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  initial
  begin
    logic [7:0] addr;
    logic [3:0] m;
    void'($urandom(32'h8a8b));
    clk         = 1'b0;
    arst_n      = 1'b0;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    special_n   = 1'b1;
    mosi        = 1'b0;
    miso_vec    = '0;
    model       = reset_regs();
    rb_check    = 1'b0;
    route_check = 1'b0;
    checks_req  = 0;
    checks_done = 0;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    run_check("reset");
    for (int n = 0; n < 150; n++)
    begin
      addr = 8'($urandom_range(16, 5));   // 5, 6, 15, 16 unknown
      if (addr == `REG_ADDR_SOFT_RST)
        addr = `REG_ADDR_LED;
      write_frame(addr, 4'($urandom), 4'($urandom), "random");
    end
    write_frame(`REG_ADDR_SOFT_RST, 4'($urandom), 4'($urandom), "soft_reset");
    write_frame(`REG_ADDR_LED, 4'h0, 4'h5, "led_set");
    // long frame ends in a zero nibble ahead of the short one
    bad_frame(32'h0007f0, 20, "long_frame");   // four extra bits ahead of a led clear
    bad_frame(32'h0007ff, 12, "short_frame");  // led toggle missing its high address nibble
    for (int k = 0; k < 4; k++)
    begin
      m = 4'($urandom_range(15, 1));
      write_frame(`REG_ADDR_MUX, ~m, m, "mux_write");  // no overlap, mux becomes m
      route_pass(8);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

  // watchdog, 200 frames worth of clk cycles
  initial
  begin
    repeat (200 * FRAME_CLKS) @(posedge clk);
    $display("watchdog expired before the tests completed");
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

//--- spi_ctrl_top.f
+incdir+include
source/spi_ctrl_pkg.sv
source/spi_frame_rx.sv
source/ctrl_reg_file.sv
source/spi_route.sv
source/spi_ctrl_top.sv
dv/spi_ctrl_checker.sv
dv/spi_ctrl_tb.sv
